// File: compile.f
hdl/cpu_pkg.sv
hdl/ctrl_if.sv
hdl/fetch_unit.sv
hdl/instr_rom.sv
hdl/control.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/dat_mem.sv
hdl/top_level.sv
verification/tb_top_level.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top_level
FLIST     ?= compile.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)
	$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then exit 1; fi
	@grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: program.hex
// one 9-bit word per line {opcode[3:0], operand[4:0]}, address 0 first
015 // 00 LDI 21
022 // 01 MVR r2
042 // 02 MVA r2
1C0 // 03 OUT -> 21
00A // 04 LDI 10
023 // 05 MVR r3
042 // 06 MVA r2
063 // 07 ADD r3
1C0 // 08 OUT -> 31
024 // 09 MVR r4
043 // 0a MVA r3
0A2 // 0b SUB r2
1C0 // 0c OUT -> 245
00F // 0d LDI 15
0E0 // 0e SHL
0E0 // 0f SHL
0E0 // 10 SHL
0E0 // 11 SHL
1C0 // 12 OUT -> 240
064 // 13 ADD r4, carry set
1C0 // 14 OUT -> 15
000 // 15 LDI 0
025 // 16 MVR r5
085 // 17 ADC r5
1C0 // 18 OUT -> 1
042 // 19 MVA r2
0C3 // 1a XOR r3, odd parity
188 // 1b BPO 8 -> 0x20
000 // 1c LDI 0, fall-through path
1C0 // 1d OUT -> 0
100 // 1e CLC
100 // 1f CLC
001 // 20 LDI 1, branch landing pad
1C0 // 21 OUT -> 1
003 // 22 LDI 3
026 // 23 MVR r6, pointer
007 // 24 LDI 7
146 // 25 STM r6
000 // 26 LDI 0
126 // 27 LDM r6
1C0 // 28 OUT -> 7
001 // 29 LDI 1
021 // 2a MVR r1, decrement
005 // 2b LDI 5
1C0 // 2c OUT, loop head
0A1 // 2d SUB r1
16C // 2e BZ 12 -> 0x30
1BD // 2f JR -3
1E0 // 30 HALT

// File: verification/tb_top_level.sv
// testbench for top_level: clock, reset, req stimulus and output stream assertions
`timescale 1ns/1ps

module tb_top_level import cpu_pkg::*; ();

  localparam int DONE_TIMEOUT = 500;      // cycles from req to done
  localparam int SETTLE       = 8;        // idle cycles watched after done

  logic  clk = 1'b0;
  logic  arst_n;
  logic  req;
  logic  done;
  logic  out_valid;
  data_t out_data;

  data_t exp_q [$];                       // expected out_data, in order
  data_t exp_head  = '0;                  // front of exp_q
  logic  exp_avail = 1'b0;                // values still expected
  int    err_cnt   = 0;
  int    pass_cnt  = 0;
  int    fail_cnt  = 0;
  logic  timed_out = 1'b0;                // done never came

  top_level #(.D(PC_W)) i_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req),
    .done      (done),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  always #20 clk = ~clk;                  // 40 ns period

  // consume one expected value per output pulse
  always @(posedge clk) begin
    if (arst_n && out_valid && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
      exp_avail <= (exp_q.size() > 0);
      exp_head  <= (exp_q.size() > 0) ? exp_q[0] : '0;
    end
  end

  assert property (@(posedge clk) disable iff (!arst_n) out_valid |-> exp_avail)
    else begin
      err_cnt++;
      $display("%0t: out_valid pulsed with no value left in the expected stream", $time);
    end

  assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && exp_avail) |-> (out_data == exp_head))
    else begin
      err_cnt++;
      $display("MISMATCH at %0t: out_data = %0d, expected %0d", $time,
               $sampled(out_data), $sampled(exp_head));
    end

  assert property (@(posedge clk) disable iff (!arst_n) $rose(done) |-> !exp_avail)
    else begin
      err_cnt++;
      $display("%0t: done rose before the whole output stream came out", $time);
    end

  assert property (@(posedge clk) disable iff (!arst_n) req |=> !done)
    else begin
      err_cnt++;
      $display("%0t: done still high in the cycle after req", $time);
    end

  // output stream worked out from the instruction rules
  task automatic build_expected_stream();
    data_t      a;
    data_t      b;
    data_t      shl;
    data_t      acc;
    logic [8:0] sum;
    a   = 8'd21;                          // r2
    b   = 8'd10;                          // r3
    acc = a + b;                          // r4
    shl = 8'd15 << 4;                     // four single shifts
    sum = {1'b0, shl} + {1'b0, acc};      // bit 8 is the carry
    exp_q.delete();
    exp_q.push_back(a);
    exp_q.push_back(acc);
    exp_q.push_back(b - a);               // wraps below zero
    exp_q.push_back(shl);
    exp_q.push_back(sum[7:0]);
    exp_q.push_back(data_t'(sum[8]));     // 0 + 0 + carry
    exp_q.push_back((^(a ^ b)) ? 8'd1 : 8'd0);  // BPO taken on odd parity
    exp_q.push_back(8'd7);                // memory round trip
    for (int i = 5; i > 0; i--) begin
      exp_q.push_back(data_t'(i));        // countdown
    end
    exp_head  <= exp_q[0];
    exp_avail <= 1'b1;
  endtask

  task automatic run_program(input string name, output logic no_done);
    int gap;
    int cyc;
    int err_before;
    no_done    = 1'b0;
    err_before = err_cnt;
    build_expected_stream();
    gap = $urandom_range(8, 1);           // random idle gap
    repeat (gap) @(negedge clk);
    req = 1'b1;
    @(negedge clk);
    req = 1'b0;
    cyc = 0;
    while (!done && cyc < DONE_TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    if (!done) begin
      no_done = 1'b1;
      fail_cnt++;
      $display("%s: done did not rise within %0d cycles", name, DONE_TIMEOUT);
    end else begin
      repeat (SETTLE) @(negedge clk);     // stray pulses after halt
      if (err_cnt == err_before) begin
        pass_cnt++;
        $display("%s: pass, done after %0d cycles", name, cyc);
      end else begin
        fail_cnt++;
        $display("%s: FAIL, %0d errors", name, err_cnt - err_before);
      end
    end
  endtask

  initial begin
    void'($urandom(75997));
    arst_n = 1'b0;
    req    = 1'b0;
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    run_program("first run after reset", timed_out);
    if (!timed_out) begin
      run_program("restart after done", timed_out);  // same stream, carry cleared at req
    end
    $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
             pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: hdl/top_level.sv
// processor top: block wiring, write-back select, registered output port
`timescale 1ns/1ps

module top_level import cpu_pkg::*; #(
  parameter int D = PC_W                 // program counter width
) (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  req,                     // one-cycle start pulse
  output logic  done,                    // high while halted
  output logic  out_valid,               // one pulse per OUT
  output data_t out_data
);

  typedef logic [D-1:0] pc_t;

  pc_t    prog_ctr;
  instr_t mach_code;
  data_t  dat_a, dat_b;                  // r0, r[n]
  data_t  rslt;                          // alu result
  data_t  mem_out;
  data_t  wb_data;                       // register write-back
  data_t  immed;
  logic   zero_q, pari_q;
  logic   running;
  logic   clr_carry;

  ctrl_if ctl_bus ();

  fetch_unit #(.D(D)) i_fetch (
    .clk      (clk),
    .arst_n   (arst_n),
    .req      (req),
    .operand  (operand_t'(mach_code[4:0])),
    .zero_q   (zero_q),
    .pari_q   (pari_q),
    .ctl      (ctl_bus),
    .prog_ctr (prog_ctr),
    .running  (running),
    .done     (done)
  );

  instr_rom #(.D(D)) i_rom (
    .prog_ctr  (prog_ctr),
    .mach_code (mach_code)
  );

  control i_ctrl (
    .mach_code (mach_code),
    .running   (running),
    .ctl       (ctl_bus)
  );

  assign immed     = {3'b000, mach_code[4:0]};  // imm5 zero-extended
  assign clr_carry = req & ~running;            // req only honoured when stopped

  alu i_alu (
    .clk       (clk),
    .arst_n    (arst_n),
    .clr_carry (clr_carry),
    .ctl       (ctl_bus),
    .in_a      (dat_a),
    .in_b      (dat_b),
    .immed     (immed),
    .rslt      (rslt),
    .zero_q    (zero_q),
    .pari_q    (pari_q)
  );

  assign wb_data = ctl_bus.mem_to_reg ? mem_out : rslt;  // LDM vs alu

  reg_file i_rf (
    .clk     (clk),
    .ctl     (ctl_bus),
    .rd_addr (reg_addr_t'(mach_code[2:0])),
    .dat_in  (wb_data),
    .dat_a   (dat_a),
    .dat_b   (dat_b)
  );

  dat_mem i_dm (
    .clk     (clk),
    .wr_en   (ctl_bus.mem_write),
    .addr    (dat_b),                    // address held in r[n]
    .dat_in  (dat_a),
    .dat_out (mem_out)
  );

  // output port, one cycle behind OUT
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) out_valid <= 1'b0;
    else         out_valid <= ctl_bus.out_en;
  end

  always_ff @(posedge clk) begin
    if (ctl_bus.out_en) out_data <= dat_a;  // r0 at the OUT
  end

endmodule

// File: hdl/dat_mem.sv
// 256 x 8 data memory, asynchronous read, synchronous write
`timescale 1ns/1ps

module dat_mem import cpu_pkg::*; (
  input  logic  clk,
  input  logic  wr_en,                   // STM
  input  data_t addr,                    // pointer from r[n]
  input  data_t dat_in,                  // r0
  output data_t dat_out
);

  data_t mem [256];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[addr] <= dat_in;
    end
  end

  assign dat_out = mem[addr];            // LDM same cycle

endmodule

// File: hdl/reg_file.sv
// eight 8-bit registers, r0 and r[n] read ports, one write port
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
  input  logic      clk,
  ctrl_if.dp        ctl,
  input  reg_addr_t rd_addr,             // n from operand
  input  data_t     dat_in,              // write-back data
  output data_t     dat_a,               // accumulator r0
  output data_t     dat_b                // r[n]
);

  data_t     regs [8];
  reg_addr_t wr_addr;

  // accumulator ops write r0, MVR writes back into r[n]
  assign wr_addr = ctl.wr_sel_r0 ? reg_addr_t'(0) : rd_addr;

  always_ff @(posedge clk) begin
    if (ctl.reg_write) begin
      regs[wr_addr] <= dat_in;
    end
  end

  assign dat_a = regs[0];
  assign dat_b = regs[rd_addr];

endmodule

// File: hdl/alu.sv
// alu with carry register and registered zero/parity flags
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  clr_carry,               // start of program
  ctrl_if.alu   ctl,
  input  data_t in_a,                    // r0
  input  data_t in_b,                    // r[n]
  input  data_t immed,                   // zero-extended imm5
  output data_t rslt,
  output logic  zero_q,
  output logic  pari_q                   // 1 = odd parity
);

  data_t opnd_b;
  logic  carry_q, carry_nxt;
  logic  r0_alu_wr;                      // result lands in r0

  assign opnd_b = ctl.alu_src ? immed : in_b;

  always_comb begin
    rslt      = in_a;                    // MVR and don't-care ops pass r0
    carry_nxt = carry_q;
    case (ctl.alu_op)
      LDI:     rslt = opnd_b;
      MVA:     rslt = opnd_b;
      ADD:     {carry_nxt, rslt} = {1'b0, in_a} + {1'b0, opnd_b};
      ADC:     {carry_nxt, rslt} = {1'b0, in_a} + {1'b0, opnd_b} + {8'd0, carry_q};
      SUB:     rslt = in_a - opnd_b;     // 8-bit wrap, carry untouched
      XOR:     rslt = in_a ^ opnd_b;
      SHL:     {carry_nxt, rslt} = {in_a, 1'b0};
      CLC:     carry_nxt = 1'b0;
      default: rslt = in_a;
    endcase
  end

  assign r0_alu_wr = ctl.alu_op inside {LDI, MVA, ADD, ADC, SUB, XOR, SHL};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      carry_q <= 1'b0;
      zero_q  <= 1'b0;
      pari_q  <= 1'b0;
    end else begin
      carry_q <= clr_carry ? 1'b0 : carry_nxt;  // req wins over the op
      if (r0_alu_wr) begin
        zero_q <= (rslt == '0);
        pari_q <= ^rslt;
      end
    end
  end

  // decoder output reaches here from the rom word through control
  assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(ctl.alu_op))
    else $error("alu: alu_op unknown");

endmodule

// File: hdl/control.sv
// opcode decoder driving the control bundle, gated by run state
`timescale 1ns/1ps

module control import cpu_pkg::*; (
  input  instr_t mach_code,
  input  logic   running,
  ctrl_if.dec    ctl
);

  opcode_e    op;
  logic [9:0] cw_dec;                    // raw control word for op
  logic [9:0] cw;                        // after run gating

  assign op = opcode_e'(mach_code[8:5]);

  // {reg_write, wr_sel_r0, mem_write, mem_to_reg, alu_src, out_en,
  //  branch_abs[1:0], branch_rel, halt}
  always_comb begin
    case (op)
      LDI:     cw_dec = 10'b11_0_0_1_0_00_0_0;  // imm through alu
      MVR:     cw_dec = 10'b10_0_0_0_0_00_0_0;  // r[n] written
      MVA:     cw_dec = 10'b11_0_0_0_0_00_0_0;
      ADD:     cw_dec = 10'b11_0_0_0_0_00_0_0;
      ADC:     cw_dec = 10'b11_0_0_0_0_00_0_0;
      SUB:     cw_dec = 10'b11_0_0_0_0_00_0_0;
      XOR:     cw_dec = 10'b11_0_0_0_0_00_0_0;
      SHL:     cw_dec = 10'b11_0_0_0_0_00_0_0;
      CLC:     cw_dec = 10'b00_0_0_0_0_00_0_0;  // carry only, inside alu
      LDM:     cw_dec = 10'b11_0_1_0_0_00_0_0;
      STM:     cw_dec = 10'b00_1_0_0_0_00_0_0;
      BZ:      cw_dec = 10'b00_0_0_0_0_01_0_0;
      BPO:     cw_dec = 10'b00_0_0_0_0_10_0_0;
      JR:      cw_dec = 10'b00_0_0_0_0_00_1_0;
      OUT:     cw_dec = 10'b00_0_0_0_1_00_0_0;
      HALT:    cw_dec = 10'b00_0_0_0_0_00_0_1;
      default: cw_dec = '0;
    endcase
  end

  assign cw = running ? cw_dec : '0;     // idle/halted: no writes, no outputs

  assign ctl.reg_write  = cw[9];
  assign ctl.wr_sel_r0  = cw[8];
  assign ctl.mem_write  = cw[7];
  assign ctl.mem_to_reg = cw[6];
  assign ctl.alu_src    = cw[5];
  assign ctl.out_en     = cw[4];
  assign ctl.branch_abs = cw[3:2];
  assign ctl.branch_rel = cw[1];
  assign ctl.halt       = cw[0];
  assign ctl.alu_op     = running ? op : HALT;  // HALT leaves alu state alone

  // fetch_unit relies on a single pc redirect per cycle
  always_comb begin
    assert ($onehot0({ctl.branch_abs, ctl.branch_rel, ctl.halt}))
      else $error("control: conflicting pc redirects for op %s", op.name());
  end

endmodule

// File: hdl/instr_rom.sv
// program store, asynchronous read, loaded from program.hex
`timescale 1ns/1ps

module instr_rom import cpu_pkg::*; #(
  parameter int D = PC_W
) (
  input  logic [D-1:0] prog_ctr,
  output instr_t       mach_code
);

  instr_t rom [2**D];                    // full pc address space

  initial begin
    for (int i = 0; i < 2**D; i++) begin
      rom[i] = {HALT, 5'd0};             // unloaded words stop the machine
    end
    $readmemh("program.hex", rom);
  end

  assign mach_code = rom[prog_ctr];

endmodule

// File: hdl/fetch_unit.sv
// program counter, absolute branch target table and run/halt fsm
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; #(
  parameter int D = PC_W
) (
  input  logic         clk,
  input  logic         arst_n,
  input  logic         req,               // start pulse
  input  operand_t     operand,
  input  logic         zero_q,
  input  logic         pari_q,
  ctrl_if.fetch        ctl,
  output logic [D-1:0] prog_ctr,
  output logic         running,
  output logic         done
);

  typedef logic [D-1:0] pc_t;

  fetch_state_e state_q, state_nxt;
  pc_t          pc_q, pc_nxt;
  pc_t          jr_target;
  pc_t          target_lut [32];          // absolute branch targets
  logic         abs_taken;

  // landing pads every 4 words, entry k -> address 4k
  always_comb begin
    for (int k = 0; k < 32; k++) begin
      target_lut[k] = pc_t'(k * 4);
    end
  end

  assign abs_taken = (ctl.branch_abs[0] & zero_q)
                   | (ctl.branch_abs[1] & pari_q);         // BZ / BPO condition
  assign jr_target = pc_q + {{(D-5){operand[4]}}, operand}; // sign-extended offset

  always_comb begin
    state_nxt = state_q;
    pc_nxt    = pc_q;                                     // hold unless running
    case (state_q)
      IDLE, HALTED: begin
        if (req) begin
          state_nxt = RUN;
          pc_nxt    = '0;                                 // restart at 0
        end
      end
      RUN: begin
        if (ctl.halt)            state_nxt = HALTED;      // pc frozen on HALT
        else if (ctl.branch_rel) pc_nxt = jr_target;
        else if (abs_taken)      pc_nxt = target_lut[operand];
        else                     pc_nxt = pc_q + pc_t'(1);
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= IDLE;
      pc_q    <= '0;
    end else begin
      state_q <= state_nxt;
      pc_q    <= pc_nxt;
    end
  end

  assign prog_ctr = pc_q;
  assign running  = (state_q == RUN);
  assign done     = (state_q == HALTED);      // level until next req

  // nothing but req may move the pc outside RUN
  assert property (@(posedge clk) disable iff (!arst_n)
    (state_q != RUN && !req) |=> $stable(pc_q))
    else $error("fetch_unit: pc changed while not running");

endmodule

// File: hdl/ctrl_if.sv
// decoded control bundle with decoder, alu, datapath and fetch modports
`timescale 1ns/1ps

interface ctrl_if import cpu_pkg::*; ();

  logic       reg_write;                 // register file write enable
  logic       wr_sel_r0;                 // write r0, else r[n]
  logic       mem_write;                 // STM
  logic       mem_to_reg;                // LDM write-back
  logic       alu_src;                   // immediate in place of r[n]
  opcode_e    alu_op;
  logic [1:0] branch_abs;                // [0] BZ, [1] BPO
  logic       branch_rel;                // JR
  logic       out_en;                    // OUT
  logic       halt;

  modport dec (
    output reg_write, wr_sel_r0, mem_write, mem_to_reg, alu_src, alu_op,
           branch_abs, branch_rel, out_en, halt
  );

  modport alu (input alu_op, alu_src);

  modport dp (input reg_write, wr_sel_r0, mem_write, mem_to_reg, out_en);

  modport fetch (input branch_abs, branch_rel, halt);

endinterface

// File: hdl/cpu_pkg.sv
// shared widths, word types, opcode enum and fetch state enum
package cpu_pkg;

  localparam int PC_W = 12;              // default program counter width

  typedef logic [7:0] data_t;            // datapath word
  typedef logic [8:0] instr_t;           // {opcode[3:0], operand[4:0]}
  typedef logic [4:0] operand_t;         // imm5, register index, table index or offset
  typedef logic [2:0] reg_addr_t;        // r0..r7

  // fixed encodings, program.hex depends on them
  typedef enum logic [3:0] {
    LDI  = 4'h0,                         // r0 <- imm5
    MVR  = 4'h1,                         // r[n] <- r0
    MVA  = 4'h2,                         // r0 <- r[n]
    ADD  = 4'h3,                         // r0 <- r0 + r[n], carry out
    ADC  = 4'h4,                         // r0 <- r0 + r[n] + c
    SUB  = 4'h5,                         // wraps at 8 bits
    XOR  = 4'h6,
    SHL  = 4'h7,                         // c <- r0[7]
    CLC  = 4'h8,
    LDM  = 4'h9,                         // r0 <- mem[r[n]]
    STM  = 4'hA,                         // mem[r[n]] <- r0
    BZ   = 4'hB,                         // zero flag -> table entry k
    BPO  = 4'hC,                         // odd parity -> table entry k
    JR   = 4'hD,                         // pc += signed offset
    OUT  = 4'hE,
    HALT = 4'hF
  } opcode_e;

  typedef enum logic [1:0] {
    IDLE,                                // waiting for first req
    RUN,                                 // one instruction per clock
    HALTED                               // done high, req restarts
  } fetch_state_e;

endpackage
